/* design/soc_bus_pkg.sv */
package soc_bus_pkg;

  // ####################
  // bus sizes
  // ####################
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = 4;
  localparam int byte_w = 8;

  // ####################
  // address map
  // ####################
  localparam logic [addr_w-1:0] sram_base  = 32'h8000_0000;
  localparam logic [addr_w-1:0] sram_mask  = 32'hf800_0000; // top five bits only
  localparam logic [addr_w-1:0] clint_base = 32'ha000_0048; // mtime lo, hi at +4
  localparam logic [addr_w-1:0] uart_base  = 32'ha000_03f8; // tx register

  localparam int sram_words = 256;
  localparam int sram_idx_w = $clog2(sram_words);

  localparam int mtime_w = 64;

  // uart fifo and pacing
  localparam int uart_fifo_depth = 4;
  localparam int uart_char_gap   = 8;
  localparam int uart_ptr_w      = $clog2(uart_fifo_depth);
  localparam int uart_cnt_w      = $clog2(uart_fifo_depth + 1);
  localparam int uart_gap_w      = $clog2(uart_char_gap);
  localparam logic [uart_gap_w-1:0] uart_gap_reload = uart_gap_w'(uart_char_gap - 1);

  // ####################
  // encodings
  // ####################
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    tgt_sram,
    tgt_clint,
    tgt_uart,
    tgt_none
  } target_e;

  // ####################
  // channels
  // ####################
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic              valid;
  } ar_req_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    resp_e             resp;
    logic              valid;
  } r_rsp_t;

  // address and data travel together
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              valid;
  } aw_w_req_t;

  typedef struct packed {
    resp_e resp;
    logic  valid;
  } b_rsp_t;

  typedef struct packed {
    logic [byte_w-1:0] data;
    logic              valid;
  } char_t;

endpackage

/* design/axi_xbar.sv */
`timescale 1ns/10ps

module axi_xbar (
  input  logic                   clk,
  input  logic                   rstn,
  // manager side
  input  soc_bus_pkg::ar_req_t   m_ar,
  output logic                   m_ar_ready,
  output soc_bus_pkg::r_rsp_t    m_r,
  input  logic                   m_r_ready,
  input  soc_bus_pkg::aw_w_req_t m_aw_w,
  output logic                   m_aw_w_ready,
  output soc_bus_pkg::b_rsp_t    m_b,
  input  logic                   m_b_ready,
  // read peripherals
  output soc_bus_pkg::ar_req_t   sram_ar,
  input  logic                   sram_ar_ready,
  input  soc_bus_pkg::r_rsp_t    sram_r,
  output logic                   sram_r_ready,
  output soc_bus_pkg::ar_req_t   clint_ar,
  input  logic                   clint_ar_ready,
  input  soc_bus_pkg::r_rsp_t    clint_r,
  output logic                   clint_r_ready,
  // write peripherals
  output soc_bus_pkg::aw_w_req_t sram_aw_w,
  input  logic                   sram_aw_w_ready,
  input  soc_bus_pkg::b_rsp_t    sram_b,
  output logic                   sram_b_ready,
  output soc_bus_pkg::aw_w_req_t uart_aw_w,
  input  logic                   uart_aw_w_ready,
  input  soc_bus_pkg::b_rsp_t    uart_b,
  output logic                   uart_b_ready
);

  function automatic soc_bus_pkg::target_e decode(
    input logic [soc_bus_pkg::addr_w-1:0] addr
  );
    soc_bus_pkg::target_e tgt;
    tgt = soc_bus_pkg::tgt_none;
    if ((addr & soc_bus_pkg::sram_mask) == soc_bus_pkg::sram_base) begin
      tgt = soc_bus_pkg::tgt_sram;
    end else if (addr[soc_bus_pkg::addr_w-1:3] ==
                 soc_bus_pkg::clint_base[soc_bus_pkg::addr_w-1:3]) begin
      tgt = soc_bus_pkg::tgt_clint; // whole 8-byte mtime region
    end else if (addr[soc_bus_pkg::addr_w-1:2] ==
                 soc_bus_pkg::uart_base[soc_bus_pkg::addr_w-1:2]) begin
      tgt = soc_bus_pkg::tgt_uart;
    end
    return tgt;
  endfunction

  soc_bus_pkg::target_e rd_dec;
  soc_bus_pkg::target_e rd_tgt;
  logic                 rd_busy;
  soc_bus_pkg::target_e wr_dec;
  soc_bus_pkg::target_e wr_tgt;
  logic                 wr_busy;

  // ####################
  // read path
  // ####################
  always_comb begin
    rd_dec = decode(m_ar.addr);
    if (rd_dec == soc_bus_pkg::tgt_uart) begin
      rd_dec = soc_bus_pkg::tgt_none; // tx port has no read side
    end
  end

  always_comb begin
    sram_ar        = m_ar;
    clint_ar       = m_ar;
    sram_ar.valid  = m_ar.valid && !rd_busy && (rd_dec == soc_bus_pkg::tgt_sram);
    clint_ar.valid = m_ar.valid && !rd_busy && (rd_dec == soc_bus_pkg::tgt_clint);
    case (rd_dec)
      soc_bus_pkg::tgt_sram:  m_ar_ready = !rd_busy && sram_ar_ready;
      soc_bus_pkg::tgt_clint: m_ar_ready = !rd_busy && clint_ar_ready;
      default:                m_ar_ready = !rd_busy; // decode error answered here
    endcase
  end

  always_comb begin
    sram_r_ready  = rd_busy && (rd_tgt == soc_bus_pkg::tgt_sram) && m_r_ready;
    clint_r_ready = rd_busy && (rd_tgt == soc_bus_pkg::tgt_clint) && m_r_ready;
    case (rd_tgt)
      soc_bus_pkg::tgt_sram:  m_r = sram_r;
      soc_bus_pkg::tgt_clint: m_r = clint_r;
      default: m_r = '{data: '0, resp: soc_bus_pkg::resp_decerr, valid: rd_busy};
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_busy <= 1'b0;
      rd_tgt  <= soc_bus_pkg::tgt_none;
    end else if (m_ar.valid && m_ar_ready) begin
      rd_busy <= 1'b1;
      rd_tgt  <= rd_dec;
    end else if (m_r.valid && m_r_ready) begin
      rd_busy <= 1'b0;
    end
  end

  // ####################
  // write path
  // ####################
  always_comb begin
    wr_dec = decode(m_aw_w.addr);
    if (wr_dec == soc_bus_pkg::tgt_clint) begin
      wr_dec = soc_bus_pkg::tgt_none; // timer is read only
    end
  end

  always_comb begin
    sram_aw_w       = m_aw_w;
    uart_aw_w       = m_aw_w;
    sram_aw_w.valid = m_aw_w.valid && !wr_busy && (wr_dec == soc_bus_pkg::tgt_sram);
    uart_aw_w.valid = m_aw_w.valid && !wr_busy && (wr_dec == soc_bus_pkg::tgt_uart);
    case (wr_dec)
      soc_bus_pkg::tgt_sram: m_aw_w_ready = !wr_busy && sram_aw_w_ready;
      soc_bus_pkg::tgt_uart: m_aw_w_ready = !wr_busy && uart_aw_w_ready;
      default:               m_aw_w_ready = !wr_busy;
    endcase
  end

  always_comb begin
    sram_b_ready = wr_busy && (wr_tgt == soc_bus_pkg::tgt_sram) && m_b_ready;
    uart_b_ready = wr_busy && (wr_tgt == soc_bus_pkg::tgt_uart) && m_b_ready;
    case (wr_tgt)
      soc_bus_pkg::tgt_sram: m_b = sram_b;
      soc_bus_pkg::tgt_uart: m_b = uart_b;
      default: m_b = '{resp: soc_bus_pkg::resp_decerr, valid: wr_busy};
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_busy <= 1'b0;
      wr_tgt  <= soc_bus_pkg::tgt_none;
    end else if (m_aw_w.valid && m_aw_w_ready) begin
      wr_busy <= 1'b1;
      wr_tgt  <= wr_dec;
    end else if (m_b.valid && m_b_ready) begin
      wr_busy <= 1'b0;
    end
  end

  // ####################
  // checks
  // ####################
  a_r_stable: assert property (@(posedge clk) disable iff (rstn)
    m_r.valid && !m_r_ready |=> $stable(m_r));

  // one read in flight until its response is taken
  a_rd_single: assert property (@(posedge clk) disable iff (rstn)
    m_ar.valid && m_ar_ready |=>
      !(sram_ar.valid || clint_ar.valid) until_with (m_r.valid && m_r_ready));

  a_wr_single: assert property (@(posedge clk) disable iff (rstn)
    m_aw_w.valid && m_aw_w_ready |=>
      !(sram_aw_w.valid || uart_aw_w.valid) until_with (m_b.valid && m_b_ready));

endmodule

/* design/sram_slave.sv */
`timescale 1ns/10ps

module sram_slave (
  input  logic                   clk,
  input  logic                   rstn,
  input  soc_bus_pkg::ar_req_t   ar,
  output logic                   ar_ready,
  output soc_bus_pkg::r_rsp_t    r,
  input  logic                   r_ready,
  input  soc_bus_pkg::aw_w_req_t aw_w,
  output logic                   aw_w_ready,
  output soc_bus_pkg::b_rsp_t    b,
  input  logic                   b_ready
);

  logic [soc_bus_pkg::data_w-1:0]     mem [soc_bus_pkg::sram_words];
  logic [soc_bus_pkg::sram_idx_w-1:0] rd_idx;
  logic [soc_bus_pkg::sram_idx_w-1:0] wr_idx;
  logic [soc_bus_pkg::data_w-1:0]     rdata_q;
  logic                               r_valid_q;
  logic                               b_valid_q;

  // word index from the low 10 address bits
  assign rd_idx = ar.addr[soc_bus_pkg::sram_idx_w+1:2];
  assign wr_idx = aw_w.addr[soc_bus_pkg::sram_idx_w+1:2];

  assign ar_ready   = !r_valid_q; // one response slot per side
  assign aw_w_ready = !b_valid_q;

  always_ff @(posedge clk) begin
    if (aw_w.valid && aw_w_ready) begin
      for (int i = 0; i < soc_bus_pkg::strb_w; i++) begin
        if (aw_w.strb[i]) begin
          mem[wr_idx][soc_bus_pkg::byte_w*i +: soc_bus_pkg::byte_w] <=
            aw_w.data[soc_bus_pkg::byte_w*i +: soc_bus_pkg::byte_w];
        end
      end
    end
    if (ar.valid && ar_ready) begin
      rdata_q <= mem[rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      if (ar.valid && ar_ready) begin
        r_valid_q <= 1'b1;
      end else if (r_valid_q && r_ready) begin
        r_valid_q <= 1'b0;
      end
      if (aw_w.valid && aw_w_ready) begin
        b_valid_q <= 1'b1;
      end else if (b_valid_q && b_ready) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  assign r = '{data: rdata_q, resp: soc_bus_pkg::resp_okay, valid: r_valid_q};
  assign b = '{resp: soc_bus_pkg::resp_okay, valid: b_valid_q};

  a_r_after_ar: assert property (@(posedge clk) disable iff (rstn)
    $rose(r_valid_q) |-> $past(ar.valid && ar_ready));

endmodule

/* design/clint_timer.sv */
`timescale 1ns/10ps

module clint_timer (
  input  logic                 clk,
  input  logic                 rstn,
  input  soc_bus_pkg::ar_req_t ar,
  output logic                 ar_ready,
  output soc_bus_pkg::r_rsp_t  r,
  input  logic                 r_ready
);

  logic [soc_bus_pkg::mtime_w-1:0] mtime;
  logic [soc_bus_pkg::data_w-1:0]  rdata_q;
  logic                            r_valid_q;

  assign ar_ready = !r_valid_q;

  // free-running cycle counter
  always_ff @(posedge clk) begin
    if (rstn) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 1'b1;
    end
  end

  // addr bit 2 picks the high word
  always_ff @(posedge clk) begin
    if (ar.valid && ar_ready) begin
      rdata_q <= ar.addr[2] ? mtime[soc_bus_pkg::mtime_w-1:soc_bus_pkg::data_w]
                            : mtime[soc_bus_pkg::data_w-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      r_valid_q <= 1'b0;
    end else if (ar.valid && ar_ready) begin
      r_valid_q <= 1'b1;
    end else if (r_valid_q && r_ready) begin
      r_valid_q <= 1'b0;
    end
  end

  assign r = '{data: rdata_q, resp: soc_bus_pkg::resp_okay, valid: r_valid_q};

endmodule

/* design/uart_tx_port.sv */
`timescale 1ns/10ps

module uart_tx_port (
  input  logic                   clk,
  input  logic                   rstn,
  input  soc_bus_pkg::aw_w_req_t aw_w,
  output logic                   aw_w_ready,
  output soc_bus_pkg::b_rsp_t    b,
  input  logic                   b_ready,
  output soc_bus_pkg::char_t     char_out
);

  logic [soc_bus_pkg::byte_w-1:0]     fifo [soc_bus_pkg::uart_fifo_depth];
  logic [soc_bus_pkg::uart_ptr_w-1:0] wr_ptr;
  logic [soc_bus_pkg::uart_ptr_w-1:0] rd_ptr;
  logic [soc_bus_pkg::uart_cnt_w-1:0] count;
  logic [soc_bus_pkg::uart_gap_w-1:0] gap_cnt;
  logic                               full;
  logic                               accept;
  logic                               push;
  logic                               pop;
  logic                               b_valid_q;
  logic [soc_bus_pkg::byte_w-1:0]     char_q;
  logic                               char_valid_q;

  assign full       = (count == soc_bus_pkg::uart_fifo_depth);
  assign aw_w_ready = !b_valid_q && !full; // stall writer when fifo full
  assign accept     = aw_w.valid && aw_w_ready;
  assign push       = accept && aw_w.strb[0]; // only byte 0 carries a char
  assign pop        = (count != '0) && (gap_cnt == '0);

  // ####################
  // fifo storage
  // ####################
  always_ff @(posedge clk) begin
    if (push) begin
      fifo[wr_ptr] <= aw_w.data[soc_bus_pkg::byte_w-1:0];
    end
    if (pop) begin
      char_q <= fifo[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      gap_cnt      <= '0;
      char_valid_q <= 1'b0;
      b_valid_q    <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
      // drain pacing
      if (pop) begin
        gap_cnt <= soc_bus_pkg::uart_gap_reload;
      end else if (gap_cnt != '0) begin
        gap_cnt <= gap_cnt - 1'b1;
      end
      char_valid_q <= pop; // single-cycle pulse
      if (accept) begin
        b_valid_q <= 1'b1;
      end else if (b_valid_q && b_ready) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  assign b        = '{resp: soc_bus_pkg::resp_okay, valid: b_valid_q};
  assign char_out = '{data: char_q, valid: char_valid_q};

  a_no_push_full: assert property (@(posedge clk) disable iff (rstn)
    push |-> count < soc_bus_pkg::uart_fifo_depth);

endmodule

/* design/soc_bus_top.sv */
`timescale 1ns/10ps

module soc_bus_top (
  input  logic                   clk,
  input  logic                   rstn,
  input  soc_bus_pkg::ar_req_t   m_ar,
  output logic                   m_ar_ready,
  output soc_bus_pkg::r_rsp_t    m_r,
  input  logic                   m_r_ready,
  input  soc_bus_pkg::aw_w_req_t m_aw_w,
  output logic                   m_aw_w_ready,
  output soc_bus_pkg::b_rsp_t    m_b,
  input  logic                   m_b_ready,
  output soc_bus_pkg::char_t     uart_char
);

  // crossbar to peripherals
  soc_bus_pkg::ar_req_t   sram_ar, clint_ar;
  soc_bus_pkg::r_rsp_t    sram_r, clint_r;
  soc_bus_pkg::aw_w_req_t sram_aw_w, uart_aw_w;
  soc_bus_pkg::b_rsp_t    sram_b, uart_b;
  logic sram_ar_ready, clint_ar_ready, sram_r_ready, clint_r_ready;
  logic sram_aw_w_ready, uart_aw_w_ready, sram_b_ready, uart_b_ready;

  axi_xbar axi_xbar_i (
    .clk, .rstn,
    .m_ar, .m_ar_ready, .m_r, .m_r_ready,
    .m_aw_w, .m_aw_w_ready, .m_b, .m_b_ready,
    .sram_ar, .sram_ar_ready, .sram_r, .sram_r_ready,
    .clint_ar, .clint_ar_ready, .clint_r, .clint_r_ready,
    .sram_aw_w, .sram_aw_w_ready, .sram_b, .sram_b_ready,
    .uart_aw_w, .uart_aw_w_ready, .uart_b, .uart_b_ready
  );

  sram_slave sram_slave_i (
    .clk, .rstn,
    .ar(sram_ar), .ar_ready(sram_ar_ready), .r(sram_r), .r_ready(sram_r_ready),
    .aw_w(sram_aw_w), .aw_w_ready(sram_aw_w_ready), .b(sram_b), .b_ready(sram_b_ready)
  );

  clint_timer clint_timer_i (
    .clk, .rstn,
    .ar(clint_ar), .ar_ready(clint_ar_ready), .r(clint_r), .r_ready(clint_r_ready)
  );

  uart_tx_port uart_tx_port_i (
    .clk, .rstn,
    .aw_w(uart_aw_w), .aw_w_ready(uart_aw_w_ready), .b(uart_b), .b_ready(uart_b_ready),
    .char_out(uart_char)
  );

endmodule

/* bench/soc_bus_ref.svh */
// expected SRAM contents and UART characters
logic [31:0] shadow [256];
logic [7:0]  exp_chars [$];

function automatic soc_bus_pkg::resp_e ref_resp(input logic [31:0] addr, input logic wr);
  logic is_sram;
  logic is_clint;
  logic is_uart;
  is_sram  = (addr[31:27] == 5'b10000);
  is_clint = (addr[31:3] == soc_bus_pkg::clint_base[31:3]); // lo and hi word
  is_uart  = (addr[31:2] == soc_bus_pkg::uart_base[31:2]);
  if (is_sram || (is_clint && !wr) || (is_uart && wr)) begin
    return soc_bus_pkg::resp_okay;
  end
  return soc_bus_pkg::resp_decerr;
endfunction

// mtime is the cycle count at the ar edge
function automatic soc_bus_pkg::r_rsp_t ref_read(input logic [31:0] addr,
                                                 input logic [63:0] mtime);
  soc_bus_pkg::r_rsp_t rsp;
  rsp = '{data: '0, resp: ref_resp(addr, 1'b0), valid: 1'b1};
  if (rsp.resp == soc_bus_pkg::resp_okay) begin
    if (addr[31:27] == 5'b10000) begin
      rsp.data = shadow[addr[9:2]];
    end else begin
      rsp.data = addr[2] ? mtime[63:32] : mtime[31:0];
    end
  end
  return rsp;
endfunction

function automatic soc_bus_pkg::b_rsp_t ref_write(input logic [31:0] addr,
                                                  input logic [31:0] data,
                                                  input logic [3:0]  strb);
  soc_bus_pkg::b_rsp_t rsp;
  rsp = '{resp: ref_resp(addr, 1'b1), valid: 1'b1};
  if (rsp.resp == soc_bus_pkg::resp_okay) begin
    if (addr[31:27] == 5'b10000) begin
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
          shadow[addr[9:2]][8*i +: 8] = data[8*i +: 8];
        end
      end
    end else if (strb[0]) begin
      exp_chars.push_back(data[7:0]); // uart keeps byte 0 only
    end
  end
  return rsp;
endfunction

/* bench/soc_bus_tb.sv */
`timescale 1ns/10ps

module soc_bus_tb;

  logic                   clk = 1'b0;
  logic                   rstn;
  soc_bus_pkg::ar_req_t   m_ar;
  logic                   m_ar_ready;
  soc_bus_pkg::r_rsp_t    m_r;
  logic                   m_r_ready;
  soc_bus_pkg::aw_w_req_t m_aw_w;
  logic                   m_aw_w_ready;
  soc_bus_pkg::b_rsp_t    m_b;
  logic                   m_b_ready;
  soc_bus_pkg::char_t     uart_char;

  integer      seed = 32'h9a94;
  logic        stall_en = 1'b0;
  logic [63:0] cyc;          // edge count since reset like mtime
  logic [31:0] waddr [16];

  `include "soc_bus_ref.svh"

  soc_bus_top soc_bus_top_i (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    if (rstn) cyc <= '0;
    else      cyc <= cyc + 1'b1;
  end

  // ####################
  // reporting
  // ####################
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_r(input string name, input soc_bus_pkg::r_rsp_t got,
                         input soc_bus_pkg::r_rsp_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                  $time, name, got, exp));
    end
  endtask

  task automatic check_b(input string name, input soc_bus_pkg::b_rsp_t got,
                         input soc_bus_pkg::b_rsp_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                  $time, name, got, exp));
    end
  endtask

  task automatic check_char(input string name, input soc_bus_pkg::char_t got,
                            input soc_bus_pkg::char_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                  $time, name, got, exp));
    end
  endtask

  // every character pulse against the expected queue
  always @(posedge clk) begin : char_compare
    soc_bus_pkg::char_t exp;
    if (!rstn && uart_char.valid) begin
      if (exp_chars.size() == 0) begin
        stop_with_failure("uart character appeared while none was expected");
      end else begin
        exp = '{data: exp_chars.pop_front(), valid: 1'b1};
        check_char("uart_char", uart_char, exp);
      end
    end
  end

  // ####################
  // bus drivers
  // ####################
  task automatic read_and_check(input logic [31:0] addr);
    soc_bus_pkg::r_rsp_t held;
    logic                held_v;
    logic [63:0]         ar_cyc;
    int                  n;
    m_ar <= '{addr: addr, valid: 1'b1};
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 60) stop_with_failure("timeout waiting for ar_ready");
    end while (!m_ar_ready);
    ar_cyc = cyc;
    m_ar <= '0;
    held_v = 1'b0;
    for (n = 0; n < 60; n++) begin
      m_r_ready <= !(stall_en && ($random(seed) & 1)); // random stall
      @(posedge clk);
      if (held_v) check_r("m_r", m_r, held); // held while stalled
      if (m_ar_ready) stop_with_failure("ar_ready rose while a read was pending");
      if (m_r.valid && m_r_ready) break;
      held   = m_r;
      held_v = m_r.valid;
    end
    if (n == 60) stop_with_failure("timeout waiting for the read response");
    check_r("m_r", m_r, ref_read(addr, ar_cyc));
    m_r_ready <= 1'b0;
  endtask

  task automatic write_and_check(input logic [31:0] addr, input logic [31:0] data,
                                 input logic [3:0] strb);
    soc_bus_pkg::b_rsp_t exp;
    soc_bus_pkg::b_rsp_t held;
    logic                held_v;
    int                  n;
    exp = ref_write(addr, data, strb);
    m_aw_w <= '{addr: addr, data: data, strb: strb, valid: 1'b1};
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 60) stop_with_failure("timeout waiting for aw_w_ready");
    end while (!m_aw_w_ready);
    m_aw_w <= '0;
    held_v = 1'b0;
    for (n = 0; n < 60; n++) begin
      m_b_ready <= !(stall_en && ($random(seed) & 1));
      @(posedge clk);
      if (held_v) check_b("m_b", m_b, held);
      if (m_aw_w_ready) stop_with_failure("aw_w_ready rose while a write was pending");
      if (m_b.valid && m_b_ready) break;
      held   = m_b;
      held_v = m_b.valid;
    end
    if (n == 60) stop_with_failure("timeout waiting for the write response");
    check_b("m_b", m_b, exp);
    m_b_ready <= 1'b0;
  endtask

  // ####################
  // test sequence
  // ####################
  initial begin
    int          i;
    int          n;
    logic [31:0] data;
    string       text;
    rstn      <= 1'b1;
    m_ar      <= '0;
    m_aw_w    <= '0;
    m_r_ready <= 1'b0;
    m_b_ready <= 1'b0;
    repeat (2) @(posedge clk);
    rstn <= 1'b0;
    repeat (2) @(posedge clk);
    if (!m_ar_ready || !m_aw_w_ready) stop_with_failure("ready outputs low after reset");

    // random sram words across the aliased region
    stall_en = 1'b1;
    for (i = 0; i < 16; i++) begin
      waddr[i] = soc_bus_pkg::sram_base | ($random(seed) & 32'h07ff_fffc);
      write_and_check(waddr[i], $random(seed), 4'hf);
    end
    for (i = 0; i < 32; i++) begin
      write_and_check(waddr[$unsigned($random(seed)) % 16], $random(seed), $random(seed));
    end
    for (i = 0; i < 16; i++) read_and_check(waddr[i]);

    // timer lo, lo again, hi
    read_and_check(soc_bus_pkg::clint_base);
    repeat ($unsigned($random(seed)) % 8) @(posedge clk);
    read_and_check(soc_bus_pkg::clint_base);
    read_and_check(soc_bus_pkg::clint_base + 4);

    // uart written faster than it drains
    stall_en = 1'b0;
    text = "soc bus uart ok";
    for (i = 0; i < text.len(); i++) begin
      data      = $random(seed);
      data[7:0] = text[i];
      write_and_check(soc_bus_pkg::uart_base, data, (i % 3 == 2) ? 4'b0110 : 4'b0001);
    end
    n = 0;
    while (exp_chars.size() != 0) begin
      @(posedge clk);
      n++;
      if (n > 300) stop_with_failure("timeout waiting for uart characters to drain");
    end

    // sram words that the bad addresses would alias to
    stall_en = 1'b1;
    write_and_check(soc_bus_pkg::sram_base | 32'h100, $random(seed), 4'hf);
    write_and_check(soc_bus_pkg::sram_base, $random(seed), 4'hf);
    write_and_check(soc_bus_pkg::sram_base | 32'h048, $random(seed), 4'hf);
    write_and_check(soc_bus_pkg::sram_base | 32'h04c, $random(seed), 4'hf);

    // decode errors then sram unchanged
    write_and_check(32'h0000_0100, $random(seed), 4'hf);
    read_and_check(32'h0000_0100);
    write_and_check(32'h9000_0000, $random(seed), 4'hf);
    read_and_check(32'h9000_0000);
    write_and_check(soc_bus_pkg::clint_base, $random(seed), 4'hf);
    write_and_check(soc_bus_pkg::clint_base + 4, $random(seed), 4'hf);
    read_and_check(soc_bus_pkg::uart_base);
    read_and_check(32'ha000_0050);
    read_and_check(soc_bus_pkg::sram_base | 32'h100);
    read_and_check(soc_bus_pkg::sram_base);
    read_and_check(soc_bus_pkg::sram_base | 32'h048);
    read_and_check(soc_bus_pkg::sram_base | 32'h04c);
    for (i = 0; i < 16; i++) read_and_check(waddr[i]);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* files.f */
+incdir+bench
design/soc_bus_pkg.sv
design/axi_xbar.sv
design/sram_slave.sv
design/clint_timer.sv
design/uart_tx_port.sv
design/soc_bus_top.sv
bench/soc_bus_tb.sv
